//--- rtl/rvf_defines.svh
`ifndef RVF_DEFINES_SVH
`define RVF_DEFINES_SVH

// ########################################
// Datapath
// ########################################

// Data and address width
`define RVF_XLEN 32

// First fetch address out of reset
`define RVF_RESET_PC 32'h8000_0000

// ########################################
// Multi-cycle execute latencies
// ########################################

`define RVF_MUL_CYCLES 3 // Multiply stall
`define RVF_DIV_CYCLES 8 // Divide stall

`endif

//--- rtl/rvf_pkg.sv
`default_nettype none

`include "rvf_defines.svh"

package rvf_pkg;

    // ########################################
    // Opcode and funct7 values
    // ########################################
    localparam logic [6:0] OP_JAL        = 7'b110_1111;
    localparam logic [6:0] OP_JALR       = 7'b110_0111;
    localparam logic [6:0] OP_LOAD       = 7'b000_0011;
    localparam logic [6:0] OP_STORE      = 7'b010_0011;
    localparam logic [6:0] OP_REG        = 7'b011_0011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001; // M extension

    // ########################################
    // Instruction word views
    // ########################################
    typedef struct packed {
        logic [11:0] imm;      // funct7 sits in imm[11:5] for R-type
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic        imm_20;   // Sign bit
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_view_t;

    typedef union packed {
        i_view_t i_view;
        j_view_t j_view;
    } inst_word_u;

    // Decode stage contents seen by sequencer and timer
    typedef struct packed {
        logic                 valid;
        logic                 is_mul;
        logic                 is_div;
        logic                 is_mem;
        logic                 is_jal;
        logic                 is_jalr;
        logic [`RVF_XLEN-1:0] pc;
        logic [`RVF_XLEN-1:0] target;
    } id_info_t;

endpackage

`default_nettype wire

//--- rtl/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvf_defines.svh"

module pc_sequencer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 fetch_done,
    input  wire rvf_pkg::id_info_t    id_info,
    input  wire logic                 mul_done,
    input  wire logic                 div_done,
    input  wire logic                 lsu_busy,
    output logic                      fetch_en,
    output logic [`RVF_XLEN-1:0]      curr_pc,
    output logic                      advance,
    output logic                      redirect_flush
);

    localparam logic [`RVF_XLEN-1:0] PC_STEP = 4;

    logic                 jalr_pending;
    logic                 jalr_pending_nxt;
    logic [`RVF_XLEN-1:0] next_pc;

    // ########################################
    // Next pc selection
    // ########################################
    always_comb begin
        next_pc          = curr_pc;
        advance          = 1'b0;
        redirect_flush   = 1'b0;
        jalr_pending_nxt = jalr_pending;
        if (fetch_done) begin
            if (id_info.is_mul) begin
                if (mul_done) begin
                    next_pc = curr_pc + PC_STEP;
                    advance = 1'b1;
                end
            end else if (id_info.is_div) begin
                if (div_done) begin
                    next_pc = curr_pc + PC_STEP;
                    advance = 1'b1;
                end
            end else if (id_info.is_mem && lsu_busy) begin
                next_pc = curr_pc;                  // Wait for LSU
            end else if (id_info.is_jalr && !jalr_pending) begin
                jalr_pending_nxt = 1'b1;            // Base read takes one fetch
            end else if (jalr_pending) begin
                next_pc          = id_info.target;
                advance          = 1'b1;
                redirect_flush   = 1'b1;
                jalr_pending_nxt = 1'b0;
            end else if (id_info.is_jal) begin
                next_pc        = id_info.target;
                advance        = 1'b1;
                redirect_flush = 1'b1;              // Drop fall-through word
            end else begin
                next_pc = curr_pc + PC_STEP;
                advance = 1'b1;
            end
        end
    end

    // ########################################
    // State
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en     <= 1'b0;
            jalr_pending <= 1'b0;
            curr_pc      <= `RVF_RESET_PC;
        end else begin
            fetch_en     <= 1'b1;
            jalr_pending <= jalr_pending_nxt;
            curr_pc      <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvf_defines.svh"

module inst_decoder (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 advance,
    input  wire logic [31:0]          fetch_data,
    input  wire logic [`RVF_XLEN-1:0] fetch_pc,
    input  wire logic [`RVF_XLEN-1:0] jalr_base,
    input  wire logic                 redirect_flush,
    output rvf_pkg::id_info_t         id_info
);

    import rvf_pkg::*;

    inst_word_u           inst_q;
    logic [`RVF_XLEN-1:0] pc_q;
    logic                 valid_q;
    logic [`RVF_XLEN-1:0] j_imm;
    logic [`RVF_XLEN-1:0] i_imm;
    logic [`RVF_XLEN-1:0] jalr_sum;
    logic                 is_muldiv;

    // ########################################
    // Decode register
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= !redirect_flush;     // Wrong path after a redirect
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            inst_q <= inst_word_u'(fetch_data);
            pc_q   <= fetch_pc;
        end
    end

    // ########################################
    // Classification and targets
    // ########################################
    assign is_muldiv = (inst_q.i_view.opcode == OP_REG) &&
                       (inst_q.i_view.imm[11:5] == FUNCT7_MULDIV);

    assign j_imm = {{(`RVF_XLEN-20){inst_q.j_view.imm_20}}, inst_q.j_view.imm_19_12,
                    inst_q.j_view.imm_11, inst_q.j_view.imm_10_1, 1'b0};
    assign i_imm = {{(`RVF_XLEN-12){inst_q.i_view.imm[11]}}, inst_q.i_view.imm};

    assign jalr_sum = jalr_base + i_imm;

    always_comb begin
        id_info.valid   = valid_q;
        id_info.is_mul  = valid_q && is_muldiv && !inst_q.i_view.funct3[2];
        id_info.is_div  = valid_q && is_muldiv && inst_q.i_view.funct3[2];
        id_info.is_mem  = valid_q && ((inst_q.i_view.opcode == OP_LOAD) ||
                                      (inst_q.i_view.opcode == OP_STORE));
        id_info.is_jal  = valid_q && (inst_q.j_view.opcode == OP_JAL);
        id_info.is_jalr = valid_q && (inst_q.i_view.opcode == OP_JALR);
        id_info.pc      = pc_q;
        if (inst_q.j_view.opcode == OP_JAL) begin
            id_info.target = pc_q + j_imm;
        end else begin
            id_info.target = {jalr_sum[`RVF_XLEN-1:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- rtl/muldiv_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvf_defines.svh"

module muldiv_timer (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire rvf_pkg::id_info_t id_info,
    input  wire logic              advance,
    output logic                   mul_done,
    output logic                   div_done
);

    localparam int CNT_W = $clog2(`RVF_DIV_CYCLES + 1);

    localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(`RVF_MUL_CYCLES - 1);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(`RVF_DIV_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic             running;

    // Counting stops once the matching flag is up
    assign running = (id_info.is_mul && !mul_done) || (id_info.is_div && !div_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            mul_done <= 1'b0;
            div_done <= 1'b0;
        end else if (advance) begin
            cnt      <= '0;                 // New word in decode
            mul_done <= 1'b0;
            div_done <= 1'b0;
        end else if (running) begin
            cnt <= cnt + 1'b1;
            if (id_info.is_mul && (cnt == MUL_LAST)) begin
                mul_done <= 1'b1;
            end
            if (id_info.is_div && (cnt == DIV_LAST)) begin
                div_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvf_defines.svh"

module fetch_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    output logic                      fetch_en,
    output logic [`RVF_XLEN-1:0]      fetch_addr,
    input  wire logic                 fetch_done,
    input  wire logic [31:0]          fetch_data,
    input  wire logic [`RVF_XLEN-1:0] jalr_base,
    input  wire logic                 lsu_busy,
    output logic [`RVF_XLEN-1:0]      id_pc,
    output logic                      id_valid
);

    import rvf_pkg::*;

    id_info_t id_info;
    logic     advance;
    logic     redirect_flush;
    logic     mul_done;
    logic     div_done;

    // ########################################
    // Sequencer, decode and timer
    // ########################################
    pc_sequencer u_pc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_done     (fetch_done),
        .id_info        (id_info),
        .mul_done       (mul_done),
        .div_done       (div_done),
        .lsu_busy       (lsu_busy),
        .fetch_en       (fetch_en),
        .curr_pc        (fetch_addr),  // Fetch address is the pc
        .advance        (advance),
        .redirect_flush (redirect_flush)
    );

    inst_decoder u_inst_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance        (advance),
        .fetch_data     (fetch_data),
        .fetch_pc       (fetch_addr),
        .jalr_base      (jalr_base),
        .redirect_flush (redirect_flush),
        .id_info        (id_info)
    );

    muldiv_timer u_muldiv_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_info  (id_info),
        .advance  (advance),
        .mul_done (mul_done),
        .div_done (div_done)
    );

    assign id_pc    = id_info.pc;
    assign id_valid = id_info.valid;

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                    // Released like any other input
    end

endmodule

`default_nettype wire

//--- verification/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvf_defines.svh"

module tb_fetch_top;

    localparam logic [31:0] BASE      = `RVF_RESET_PC;
    localparam logic [31:0] JALR_BASE = 32'h8000_0100;
    localparam logic [31:0] JAL_PC    = BASE + 32'h40;
    localparam int          WAIT_MAX  = 400;

    logic        clk;
    logic        rst_n;
    logic        fetch_en;
    logic [31:0] fetch_addr;
    logic        fetch_done;
    logic [31:0] fetch_data;
    logic [31:0] jalr_base;
    logic        lsu_busy;
    logic [31:0] id_pc;
    logic        id_valid;

    logic [31:0] prog [logic [31:0]];  // Program table by byte address
    logic [31:0] lfsr;
    int          wait_cnt;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    // Reference model state
    logic [31:0] exp_pc;
    logic        exp_valid;
    logic [31:0] exp_id_pc;
    logic [31:0] ref_word;
    logic        ref_pending;
    int          ref_age;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) u_clock (.clk(clk), .rst_n(rst_n));

    fetch_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .jalr_base  (jalr_base),
        .lsu_busy   (lsu_busy),
        .id_pc      (id_pc),
        .id_valid   (id_valid)
    );

    // ########################################
    // Helpers
    // ########################################
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // OP-IMM words, never classified as anything special
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        logic [31:0] mix;
        mix = a ^ (a >> 7) ^ (a << 11);
        return {mix[31:7], 7'b001_0011};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        return fill_word(a);
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b110_1111};
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        error_count++;
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic wait_addr(input logic [31:0] addr);
        int n;
        n = 0;
        while (fetch_addr !== addr && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (fetch_addr !== addr) begin
            note_failure($sformatf("timeout while waiting for fetch_addr %h", addr));
        end
    endtask

    task automatic wait_decode(input logic [31:0] pc);
        int n;
        n = 0;
        while (!(id_valid && id_pc == pc) && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!(id_valid && id_pc == pc)) begin
            note_failure($sformatf("timeout while waiting for pc %h in decode", pc));
        end
    endtask

    // ########################################
    // Memory model
    // ########################################
    always @(posedge clk) begin
        #1;
        if (fetch_done) begin
            fetch_done = 1'b0;
            random_bits(2, wait_cnt);
            wait_cnt = wait_cnt % 3;        // 1 to 3 idle cycles
        end else if (fetch_en && rst_n) begin
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else begin
                fetch_data = mem_read(fetch_addr);
                fetch_done = 1'b1;
            end
        end
    end

    // ########################################
    // Reference model
    // ########################################
    always @(posedge clk or negedge rst_n) begin : ref_model
        logic [6:0]  op;
        logic        md;
        logic        is_mul;
        logic        is_div;
        logic        is_mem;
        logic        is_jal;
        logic        is_jalr;
        logic        adv;
        logic        flush;
        logic        pend;
        logic [31:0] nxt;
        logic [31:0] jal_tgt;
        logic [31:0] jalr_tgt;
        if (!rst_n) begin
            exp_pc      <= `RVF_RESET_PC;
            exp_valid   <= 1'b0;
            exp_id_pc   <= '0;
            ref_word    <= '0;
            ref_pending <= 1'b0;
            ref_age     <= 0;
        end else begin
            op       = ref_word[6:0];
            md       = (op == 7'h33) && (ref_word[31:25] == 7'h01);
            is_mul   = exp_valid && md && !ref_word[14];
            is_div   = exp_valid && md && ref_word[14];
            is_mem   = exp_valid && (op == 7'h03 || op == 7'h23);
            is_jal   = exp_valid && op == 7'h6f;
            is_jalr  = exp_valid && op == 7'h67;
            jal_tgt  = exp_id_pc + {{11{ref_word[31]}}, ref_word[31], ref_word[19:12],
                                    ref_word[20], ref_word[30:21], 1'b0};
            jalr_tgt = (jalr_base + {{20{ref_word[31]}}, ref_word[31:20]}) & ~32'd1;
            nxt      = exp_pc;
            adv      = 1'b0;
            flush    = 1'b0;
            pend     = ref_pending;
            if (fetch_done) begin
                if (is_mul || is_div) begin
                    adv = ref_age >= (is_mul ? `RVF_MUL_CYCLES : `RVF_DIV_CYCLES);
                end else if (is_mem && lsu_busy) begin
                    adv = 1'b0;
                end else if (is_jalr && !ref_pending) begin
                    pend = 1'b1;
                end else if (ref_pending) begin
                    {adv, flush, pend} = 3'b110;
                    nxt = jalr_tgt;
                end else if (is_jal) begin
                    {adv, flush} = 2'b11;
                    nxt = jal_tgt;
                end else begin
                    adv = 1'b1;
                end
                if (adv && !flush) begin
                    nxt = exp_pc + 32'd4;
                end
            end
            if (adv) begin
                exp_valid <= !flush;
                ref_word  <= fetch_data;
                exp_id_pc <= exp_pc;
                ref_age   <= 0;
            end else if (is_mul || is_div) begin
                ref_age <= ref_age + 1;
            end
            exp_pc      <= nxt;
            ref_pending <= pend;
        end
    end

    // ########################################
    // Assertions
    // ########################################
    a_pc: assert property (@(posedge clk) disable iff (!rst_n) fetch_addr == exp_pc)
        else report_value("fetch_addr", exp_pc, fetch_addr);

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) id_valid == exp_valid)
        else report_value("id_valid", exp_valid, id_valid);

    a_id_pc: assert property (@(posedge clk) disable iff (!rst_n) exp_valid |-> id_pc == exp_id_pc)
        else report_value("id_pc", exp_id_pc, id_pc);

    // Fall-through word of the jal is never valid
    a_wrong_path: assert property (@(posedge clk) disable iff (!rst_n)
        !(id_valid && id_pc == JAL_PC + 32'd4))
        else note_failure($sformatf("wrong-path word at pc %h shown as valid at %0t ns",
                                    id_pc, $time));

    // ########################################
    // Tests
    // ########################################
    initial begin
        int errs;
        int span;
        int n;
        fetch_done   = 1'b0;
        fetch_data   = '0;
        jalr_base    = JALR_BASE;
        lsu_busy     = 1'b0;
        lfsr         = 32'h4f53_43c4;
        wait_cnt     = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;

        prog[BASE + 32'h20] = 32'h0220_80b3;            // mul x1, x1, x2
        prog[BASE + 32'h24] = 32'h0220_c0b3;            // div x1, x1, x2
        prog[BASE + 32'h30] = 32'h0000_a183;            // lw x3, 0(x1)
        prog[JAL_PC]        = enc_jal(21'h40);          // To BASE + 0x80
        prog[BASE + 32'h90] = {12'h015, 5'd5, 3'b000, 5'd0, 7'b110_0111};

        errs = error_count;
        n = 0;
        while (!rst_n && n < WAIT_MAX) begin
            #1;
            n++;
        end
        if (!rst_n) begin
            note_failure("timeout while waiting for reset release");
        end
        a_rst_pc: assert (fetch_addr == BASE) else report_value("fetch_addr", BASE, fetch_addr);
        a_rst_en: assert (fetch_en == 1'b0) else report_value("fetch_en", 0, fetch_en);
        a_rst_vld: assert (id_valid == 1'b0) else report_value("id_valid", 0, id_valid);
        @(posedge clk);
        #1;
        a_en_rise: assert (fetch_en == 1'b1) else report_value("fetch_en", 1, fetch_en);
        finish_test("reset", errs);

        errs = error_count;
        wait_addr(BASE + 32'h20);
        finish_test("straight line", errs);

        errs = error_count;
        wait_addr(BASE + 32'h2c);
        finish_test("multiply and divide", errs);

        errs = error_count;
        wait_decode(BASE + 32'h30);
        lsu_busy = 1'b1;
        @(posedge clk);
        #1;
        random_bits(3, span);
        repeat (span + 3) @(posedge clk);   // Covers the next fetch_done
        #1 lsu_busy = 1'b0;
        wait_addr(BASE + 32'h38);
        finish_test("load stall", errs);

        errs = error_count;
        wait_addr(BASE + 32'h88);
        finish_test("jal", errs);

        errs = error_count;
        wait_addr(BASE + 32'h11c);
        finish_test("jalr", errs);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/rvf_pkg.sv
rtl/pc_sequencer.sv
rtl/inst_decoder.sv
rtl/muldiv_timer.sv
rtl/fetch_top.sv
verification/tb_clock.sv
verification/tb_fetch_top.sv

//--- Bender.yml
package:
  name: rvf_fetch

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rvf_pkg.sv
      - rtl/pc_sequencer.sv
      - rtl/inst_decoder.sv
      - rtl/muldiv_timer.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_clock.sv
      - verification/tb_fetch_top.sv
